//--- source/basics_int.sv
`timescale 1ns/1ps

module basics_int (
	input  logic                    clk,
	input  logic                    reset,
	input  ice_bus_pkg::ma_bus_t    ma,
	output logic                    sl_request,
	input  logic                    sl_grant,
	input  logic                    sl_latch,
	output ice_bus_pkg::sl_beat_t   sl_beat,
	output ice_reg_pkg::gpio_cfg_t  gpio_cfg
);

	logic                     frame_d;
	logic                     mine;
	logic [1:0]               beat_cnt;
	logic [1:0]               byte_idx;
	logic                     frame_start;
	logic                     frame_end;
	logic                     take;
	logic                     is_query;
	logic                     sel_ok;
	ice_bus_pkg::dev_addr_t   frame_addr;
	ice_bus_pkg::dev_addr_t   resp_addr;
	ice_bus_pkg::char_t       evt_id;
	ice_reg_pkg::gpio_reg_e   reg_sel;
	ice_reg_pkg::gpio_vec_t   reg_value;

	// Frame edges seen on the master bus
	assign frame_start = ma.frame_valid && !frame_d;
	assign frame_end = !ma.frame_valid && frame_d;
	assign take = sl_latch && sl_grant;
	assign is_query = (resp_addr == ice_bus_pkg::ADDR_VERSION);

	// Write needs id, select and value, plus a known select
	always_comb begin
		case (reg_sel)
			ice_reg_pkg::REG_DIRECTION,
			ice_reg_pkg::REG_LEVEL,
			ice_reg_pkg::REG_INT_ENABLE: sel_ok = (beat_cnt == 2'd3);
			default: sel_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_d <= 1'b0;
			mine <= 1'b0;
			beat_cnt <= '0;
			byte_idx <= '0;
			sl_request <= 1'b0;
			gpio_cfg <= '0;
		end else begin
			frame_d <= ma.frame_valid;
			if (frame_start) begin
				// Frames arriving while a reply waits are dropped
				mine <= !sl_request &&
					(ma.addr == ice_bus_pkg::ADDR_VERSION ||
					 ma.addr == ice_bus_pkg::ADDR_GPIO_WR);
				beat_cnt <= '0;
			end else if (mine && ma.data_valid && beat_cnt != 2'd3) begin
				// Saturates once the value byte is in
				beat_cnt <= beat_cnt + 2'd1;
			end
			if (frame_end && mine) begin
				mine <= 1'b0;
				sl_request <= 1'b1;
				byte_idx <= '0;
				if (frame_addr == ice_bus_pkg::ADDR_GPIO_WR && sel_ok) begin
					case (reg_sel)
						ice_reg_pkg::REG_DIRECTION: gpio_cfg.direction <= reg_value;
						ice_reg_pkg::REG_LEVEL: gpio_cfg.level <= reg_value;
						default: gpio_cfg.int_enable <= reg_value;
					endcase
				end
			end else if (take) begin
				// Step to next reply byte
				byte_idx <= byte_idx + 2'd1;
				if (sl_beat.last) begin
					sl_request <= 1'b0;
				end
			end
		end
	end

	// Frame contents and reply header
	always_ff @(posedge clk) begin
		if (frame_start) begin
			frame_addr <= ma.addr;
		end
		if (mine && ma.data_valid) begin
			case (beat_cnt)
				2'd0: evt_id <= ma.data;
				2'd1: reg_sel <= ice_reg_pkg::gpio_reg_e'(ma.data);
				2'd2: reg_value <= ma.data;
				default: ;
			endcase
		end
		if (frame_end && mine) begin
			if (frame_addr == ice_bus_pkg::ADDR_VERSION) begin
				resp_addr <= ice_bus_pkg::ADDR_VERSION;
			end else if (sel_ok) begin
				resp_addr <= ice_bus_pkg::ADDR_ACK;
			end else begin
				resp_addr <= ice_bus_pkg::ADDR_NAK;
			end
		end
	end

	// Query reply is four bytes, ACK/NAK three
	always_comb begin
		sl_beat.valid = sl_request;
		sl_beat.last = is_query ? (byte_idx == 2'd3) : (byte_idx == 2'd2);
		case (byte_idx)
			2'd0: sl_beat.data = resp_addr;
			2'd1: sl_beat.data = evt_id;
			2'd2: sl_beat.data = is_query ? 8'd1 : 8'd0;
			default: sl_beat.data = ice_reg_pkg::VERSION;
		endcase
	end

	// Unlatched beat stays offered and unchanged
	a_beat_held: assert property (@(posedge clk) disable iff (reset)
		(sl_beat.valid && !take) |=> (sl_request && $stable(sl_beat)));

endmodule

//--- source/global_event_counter.sv
`timescale 1ns/1ps

module global_event_counter (
	input  logic               clk,
	input  logic               reset,
	input  logic               incr,
	output ice_bus_pkg::tag_t  tag
);

	// Shared time tag for all event sources
	// Wraps at 8 bits
	always_ff @(posedge clk) begin
		if (reset) begin
			tag <= '0;
		end else if (incr) begin
			// One step per cycle with incr high
			tag <= tag + 1'b1;
		end
	end

endmodule

//--- source/gpio_int.sv
`timescale 1ns/1ps

module gpio_int (
	input  logic                    clk,
	input  logic                    reset,
	input  ice_reg_pkg::gpio_cfg_t  gpio_cfg,
	input  ice_reg_pkg::gpio_vec_t  gpio_in,
	output ice_reg_pkg::gpio_vec_t  gpio_out,
	output ice_reg_pkg::gpio_vec_t  gpio_oe,
	input  ice_bus_pkg::tag_t       tag,
	output logic                    incr,
	output logic                    sl_request,
	input  logic                    sl_grant,
	input  logic                    sl_latch,
	output ice_bus_pkg::sl_beat_t   sl_beat
);

	ice_reg_pkg::gpio_vec_t  sync1;
	ice_reg_pkg::gpio_vec_t  sync2;
	ice_reg_pkg::gpio_vec_t  last_rep;
	ice_reg_pkg::gpio_vec_t  evt_levels;
	ice_bus_pkg::tag_t       evt_tag;
	logic [1:0]              byte_idx;
	logic                    changed;
	logic                    take;
	logic                    levels_open;

	// Enabled bits differing from last report
	assign changed = |((sync2 ^ last_rep) & gpio_cfg.int_enable);
	assign take = sl_latch && sl_grant;
	// Levels still merge until their byte is on offer
	assign levels_open = sl_request && byte_idx != 2'd3;

	always_ff @(posedge clk) begin
		if (reset) begin
			gpio_out <= '0;
			gpio_oe <= '0;
			sync1 <= '0;
			sync2 <= '0;
			last_rep <= '0;
			incr <= 1'b0;
			sl_request <= 1'b0;
			byte_idx <= '0;
		end else begin
			// Pads follow settings
			gpio_out <= gpio_cfg.level;
			gpio_oe <= gpio_cfg.direction;
			// Two flop synchronizer
			sync1 <= gpio_in;
			sync2 <= sync1;
			incr <= 1'b0;
			if (!sl_request) begin
				if (changed) begin
					sl_request <= 1'b1;
					incr <= 1'b1;
					byte_idx <= '0;
					last_rep <= sync2;
				end else begin
					// Disabled bits tracked silently
					last_rep <= (last_rep & gpio_cfg.int_enable) |
						(sync2 & ~gpio_cfg.int_enable);
				end
			end else begin
				if (levels_open) begin
					last_rep <= sync2;
				end
				if (take) begin
					byte_idx <= byte_idx + 2'd1;
					if (sl_beat.last) begin
						sl_request <= 1'b0;
					end
				end
			end
		end
	end

	// Event payload, tag taken before the counter steps
	always_ff @(posedge clk) begin
		if (!sl_request && changed) begin
			evt_tag <= tag;
			evt_levels <= sync2;
		end else if (levels_open) begin
			evt_levels <= sync2;
		end
	end

	// Event frame 'g', tag, 1, levels
	always_comb begin
		sl_beat.valid = sl_request;
		sl_beat.last = (byte_idx == 2'd3);
		case (byte_idx)
			2'd0: sl_beat.data = ice_bus_pkg::ADDR_GPIO_EVT;
			2'd1: sl_beat.data = evt_tag;
			2'd2: sl_beat.data = 8'd1;
			default: sl_beat.data = evt_levels;
		endcase
	end

endmodule

//--- source/ice_bus.sv
`timescale 1ns/1ps

module ice_bus (
	input  logic                    clk,
	input  logic                    reset,
	input  ice_bus_pkg::char_t      rx_char,
	input  logic                    rx_char_valid,
	output ice_bus_pkg::char_t      tx_char,
	output logic                    tx_char_valid,
	input  logic                    tx_char_ready,
	input  ice_reg_pkg::gpio_vec_t  gpio_in,
	output ice_reg_pkg::gpio_vec_t  gpio_out,
	output ice_reg_pkg::gpio_vec_t  gpio_oe
);

	// Slot 0 basics, slot 1 GPIO
	localparam int NUM_DEV = 2;

	ice_bus_pkg::ma_bus_t    ma;
	logic [NUM_DEV-1:0]      sl_request;
	logic [NUM_DEV-1:0]      sl_grant;
	ice_bus_pkg::sl_beat_t   sl_beat [NUM_DEV];
	logic                    sl_latch;
	ice_reg_pkg::gpio_cfg_t  gpio_cfg;
	ice_bus_pkg::tag_t       tag;
	logic                    gpio_incr;

	ice_bus_controller #(.NUM_DEV(NUM_DEV)) ice1 (
		.clk(clk),
		.reset(reset),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.tx_char(tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready),
		.ma(ma),
		.sl_request(sl_request),
		.sl_grant(sl_grant),
		.sl_beat(sl_beat),
		.sl_latch(sl_latch)
	);

	// Version queries and GPIO settings
	basics_int bi0 (
		.clk(clk),
		.reset(reset),
		.ma(ma),
		.sl_request(sl_request[0]),
		.sl_grant(sl_grant[0]),
		.sl_latch(sl_latch),
		.sl_beat(sl_beat[0]),
		.gpio_cfg(gpio_cfg)
	);

	gpio_int gi1 (
		.clk(clk),
		.reset(reset),
		.gpio_cfg(gpio_cfg),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.tag(tag),
		.incr(gpio_incr),
		.sl_request(sl_request[1]),
		.sl_grant(sl_grant[1]),
		.sl_latch(sl_latch),
		.sl_beat(sl_beat[1])
	);

	// Time tags for events
	global_event_counter gec1 (
		.clk(clk),
		.reset(reset),
		.incr(gpio_incr),
		.tag(tag)
	);

endmodule

//--- source/ice_bus_controller.sv
`timescale 1ns/1ps

module ice_bus_controller #(
	parameter int NUM_DEV = 2
) (
	input  logic                   clk,
	input  logic                   reset,
	input  ice_bus_pkg::char_t     rx_char,
	input  logic                   rx_char_valid,
	output ice_bus_pkg::char_t     tx_char,
	output logic                   tx_char_valid,
	input  logic                   tx_char_ready,
	output ice_bus_pkg::ma_bus_t   ma,
	input  logic [NUM_DEV-1:0]     sl_request,
	output logic [NUM_DEV-1:0]     sl_grant,
	input  ice_bus_pkg::sl_beat_t  sl_beat [NUM_DEV],
	output logic                   sl_latch
);

	localparam int IDX_W = (NUM_DEV > 1) ? $clog2(NUM_DEV) : 1;

	typedef enum logic [1:0] {IDLE, EVT_ID, LENGTH, DATA} parse_state_e;

	parse_state_e           state;
	ice_bus_pkg::char_t     remaining;
	logic [IDX_W-1:0]       last_idx;
	logic [IDX_W-1:0]       next_idx;
	logic [NUM_DEV-1:0]     next_grant;
	logic                   next_found;
	ice_bus_pkg::sl_beat_t  cur_beat;

	// Host frame parser
	// Every bus field is registered so data lags rx by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			remaining <= '0;
			ma <= '0;
		end else begin
			ma.data_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (rx_char_valid) begin
						// Address byte opens the frame
						ma.addr <= rx_char;
						ma.frame_valid <= 1'b1;
						state <= EVT_ID;
					end else begin
						// Drops one cycle after the closing beat
						ma.frame_valid <= 1'b0;
					end
				end
				EVT_ID: begin
					if (rx_char_valid) begin
						// Event id goes out as first beat
						ma.data <= rx_char;
						ma.data_valid <= 1'b1;
						state <= LENGTH;
					end
				end
				LENGTH: begin
					if (rx_char_valid) begin
						// Length is kept here and never broadcast
						remaining <= rx_char;
						if (rx_char == '0) begin
							ma.frame_valid <= 1'b0;
							state <= IDLE;
						end else begin
							state <= DATA;
						end
					end
				end
				DATA: begin
					if (rx_char_valid) begin
						ma.data <= rx_char;
						ma.data_valid <= 1'b1;
						remaining <= remaining - 1'b1;
						// Last payload byte
						if (remaining == 8'd1) begin
							state <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Round robin pick starting one slot after the last winner
	always_comb begin
		int unsigned idx;
		next_found = 1'b0;
		next_idx = last_idx;
		next_grant = '0;
		for (int i = 1; i <= NUM_DEV; i++) begin
			idx = (int'(last_idx) + i) % NUM_DEV;
			if (!next_found && sl_request[idx]) begin
				next_found = 1'b1;
				next_idx = IDX_W'(idx);
				next_grant[idx] = 1'b1;
			end
		end
	end

	// Grant is held for a whole response frame
	always_ff @(posedge clk) begin
		if (reset) begin
			sl_grant <= '0;
			last_idx <= '0;
		end else if (sl_grant == '0) begin
			if (next_found) begin
				sl_grant <= next_grant;
				last_idx <= next_idx;
			end
		end else if (sl_latch && cur_beat.last) begin
			// Release after the final byte goes out
			sl_grant <= '0;
		end
	end

	// Beat of the granted device
	always_comb begin
		cur_beat = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (sl_grant[i]) begin
				cur_beat = sl_beat[i];
			end
		end
	end

	// Byte moves only when the host side can take it
	assign sl_latch = cur_beat.valid && tx_char_ready;
	assign tx_char_valid = sl_latch;
	assign tx_char = cur_beat.data;

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(sl_grant));

	// No interleaving of two response frames
	// Granted device keeps its request until the last byte is taken
	a_grant_held: assert property (@(posedge clk) disable iff (reset)
		((sl_grant != '0) && !(sl_latch && cur_beat.last)) |=>
		($stable(sl_grant) && ((sl_grant & sl_request) != '0)));

	// Forwarded bytes come from a device still holding its request
	a_tx_ready: assert property (@(posedge clk) disable iff (reset)
		tx_char_valid |-> (tx_char_ready && ((sl_grant & sl_request) != '0)));

endmodule

//--- source/ice_bus_pkg.sv
package ice_bus_pkg;

	// One host character on the byte stream
	typedef logic [7:0] char_t;

	// Frame address character, picks the device function
	typedef logic [7:0] dev_addr_t;

	// Global event counter value
	typedef logic [7:0] tag_t;

	// Addresses understood by the kept devices
	localparam dev_addr_t ADDR_VERSION = 8'h76;
	localparam dev_addr_t ADDR_GPIO_WR = 8'h47;
	// Async GPIO change report
	localparam dev_addr_t ADDR_GPIO_EVT = 8'h67;
	// Replies to a register write
	localparam dev_addr_t ADDR_ACK = 8'h41;
	localparam dev_addr_t ADDR_NAK = 8'h4e;

	// Master bus, broadcast by the controller to every device
	typedef struct packed {
		// High from address byte until frame close
		logic      frame_valid;
		// Single cycle strobe per data byte
		logic      data_valid;
		dev_addr_t addr;
		char_t     data;
	} ma_bus_t;

	// One response byte offered by a device
	typedef struct packed {
		logic  valid;
		// Final byte of the response frame
		logic  last;
		char_t data;
	} sl_beat_t;

endpackage

//--- source/ice_reg_pkg.sv
package ice_reg_pkg;

	// Number of GPIO pads
	localparam int GPIO_WIDTH = 8;

	typedef logic [GPIO_WIDTH-1:0] gpio_vec_t;

	// Register select byte of a 'G' write
	typedef enum logic [7:0] {
		REG_DIRECTION  = 8'd0,
		REG_LEVEL      = 8'd1,
		REG_INT_ENABLE = 8'd2
	} gpio_reg_e;

	// GPIO settings held by the basics device
	typedef struct packed {
		// 1 = pad drives out
		gpio_vec_t direction;
		gpio_vec_t level;
		// Bits that raise events on change
		gpio_vec_t int_enable;
	} gpio_cfg_t;

	// Answer to a version query
	localparam logic [7:0] VERSION = 8'h13;

endpackage

//--- src.f
source/ice_bus_pkg.sv
source/ice_reg_pkg.sv
source/global_event_counter.sv
source/ice_bus_controller.sv
source/basics_int.sv
source/gpio_int.sv
source/ice_bus.sv
verif/ice_bus_tb.sv

//--- verif/ice_bus_tb.sv
`timescale 1ns/1ps

module ice_bus_tb;

	// Cycles allowed between two response bytes
	localparam int BYTE_TIMEOUT = 100;
	// Send plus four response bytes
	localparam int FRAME_WORST = 4 * BYTE_TIMEOUT + 10;
	// Reset, then all tests at their worst case
	localparam int TEST_WORST = 10 + 13 * FRAME_WORST + 60;
	localparam int WATCHDOG_CYCLES = 4 * TEST_WORST;

	// Frame characters
	localparam ice_bus_pkg::char_t CH_VERSION = "v";
	localparam ice_bus_pkg::char_t CH_GPIO_WR = "G";
	localparam ice_bus_pkg::char_t CH_GPIO_EVT = "g";
	localparam ice_bus_pkg::char_t CH_ACK = "A";
	localparam ice_bus_pkg::char_t CH_NAK = "N";
	localparam ice_bus_pkg::char_t VERSION_BYTE = 8'h13;

	logic                    clk;
	logic                    reset;
	ice_bus_pkg::char_t      rx_char;
	logic                    rx_char_valid;
	ice_bus_pkg::char_t      tx_char;
	logic                    tx_char_valid;
	logic                    tx_char_ready;
	ice_reg_pkg::gpio_vec_t  gpio_in;
	ice_reg_pkg::gpio_vec_t  gpio_out;
	ice_reg_pkg::gpio_vec_t  gpio_oe;

	// Bytes seen on the host side, oldest first
	ice_bus_pkg::char_t      rx_q [$];
	// Last frame pulled from the queue
	ice_bus_pkg::char_t      f_addr;
	ice_bus_pkg::char_t      f_id;
	ice_bus_pkg::char_t      f_len;
	ice_bus_pkg::char_t      f_data;
	ice_bus_pkg::tag_t       next_tag;
	logic                    tag_known;
	ice_reg_pkg::gpio_vec_t  dir_val;
	ice_reg_pkg::gpio_vec_t  level_val;
	logic                    bp_done;
	int                      errors;
	int                      tests_run;
	int                      tests_failed;

	ice_bus i_dut (
		.clk(clk),
		.reset(reset),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.tx_char(tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Sampled mid cycle, where tx lines are settled
	task automatic collect_bytes();
		forever begin
			@(negedge clk);
			if (tx_char_valid) begin
				rx_q.push_back(tx_char);
			end
		end
	endtask

	initial collect_bytes();

	task automatic send_char(ice_bus_pkg::char_t c);
		@(posedge clk);
		rx_char <= c;
		rx_char_valid <= 1'b1;
	endtask

	// Address, id, length, then up to two data bytes
	task automatic send_frame(ice_bus_pkg::char_t addr, ice_bus_pkg::char_t id,
			ice_bus_pkg::char_t len, ice_bus_pkg::char_t d0, ice_bus_pkg::char_t d1);
		send_char(addr);
		send_char(id);
		send_char(len);
		if (len > 8'd0) begin
			send_char(d0);
		end
		if (len > 8'd1) begin
			send_char(d1);
		end
		@(posedge clk);
		rx_char_valid <= 1'b0;
	endtask

	task automatic wait_byte(output ice_bus_pkg::char_t b);
		int waited;
		waited = 0;
		b = '0;
		while (rx_q.size() == 0 && waited < BYTE_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (rx_q.size() == 0) begin
			$display("ERROR at %0t ns: no response byte arrived within %0d cycles",
				$time, BYTE_TIMEOUT);
			errors++;
		end else begin
			b = rx_q.pop_front();
		end
	endtask

	// Frames here carry at most one data byte
	task automatic get_frame();
		wait_byte(f_addr);
		wait_byte(f_id);
		wait_byte(f_len);
		f_data = '0;
		if (f_len != 8'd0) begin
			wait_byte(f_data);
		end
	endtask

	task automatic check_char(string name, ice_bus_pkg::char_t exp, ice_bus_pkg::char_t act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected 8'h%02h got 8'h%02h",
				$time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_gpio(string name, ice_reg_pkg::gpio_vec_t exp,
			ice_reg_pkg::gpio_vec_t act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected 8'h%02h got 8'h%02h",
				$time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_query_reply(ice_bus_pkg::char_t id);
		check_char("reply addr", CH_VERSION, f_addr);
		check_char("reply id", id, f_id);
		check_char("reply length", 8'd1, f_len);
		check_char("version", VERSION_BYTE, f_data);
	endtask

	// Tags step by one from the first one seen
	task automatic check_event_frame(ice_reg_pkg::gpio_vec_t levels);
		check_char("event addr", CH_GPIO_EVT, f_addr);
		if (!tag_known) begin
			next_tag = f_id;
			tag_known = 1'b1;
		end
		check_char("event tag", next_tag, f_id);
		next_tag++;
		check_char("event length", 8'd1, f_len);
		check_gpio("event levels", levels, ice_reg_pkg::gpio_vec_t'(f_data));
	endtask

	task automatic write_reg(ice_bus_pkg::char_t sel, ice_bus_pkg::char_t value,
			ice_bus_pkg::char_t exp_addr);
		ice_bus_pkg::char_t id;
		id = 8'($urandom);
		send_frame(CH_GPIO_WR, id, 8'd2, sel, value);
		get_frame();
		check_char("write reply addr", exp_addr, f_addr);
		check_char("write reply id", id, f_id);
		check_char("write reply length", 8'd0, f_len);
	endtask

	task automatic end_test(string name, int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic query_version();
		int err0;
		ice_bus_pkg::char_t id;
		err0 = errors;
		id = 8'($urandom);
		send_frame(CH_VERSION, id, 8'd0, 8'd0, 8'd0);
		get_frame();
		check_query_reply(id);
		end_test("version query", err0);
	endtask

	task automatic write_direction_level();
		int err0;
		err0 = errors;
		dir_val = 8'($urandom);
		level_val = 8'($urandom);
		write_reg(8'd0, dir_val, CH_ACK);
		@(negedge clk);
		check_gpio("gpio_oe", dir_val, gpio_oe);
		write_reg(8'd1, level_val, CH_ACK);
		@(negedge clk);
		check_gpio("gpio_out", level_val, gpio_out);
		check_gpio("gpio_oe", dir_val, gpio_oe);
		end_test("direction and level writes", err0);
	endtask

	// Selects from 3 upward are not registers
	task automatic write_bad_select();
		int err0;
		ice_bus_pkg::char_t sel;
		err0 = errors;
		sel = 8'd3 + 8'($urandom % 253);
		write_reg(sel, ~level_val, CH_NAK);
		@(negedge clk);
		check_gpio("gpio_out", level_val, gpio_out);
		check_gpio("gpio_oe", dir_val, gpio_oe);
		end_test("invalid register select", err0);
	endtask

	task automatic gpio_change_events();
		int err0;
		int i;
		ice_reg_pkg::gpio_vec_t exp_lv;
		err0 = errors;
		// Low nibble raises events, bit 7 stays quiet
		write_reg(8'd2, 8'h0f, CH_ACK);
		for (i = 0; i < 3; i++) begin
			exp_lv = gpio_in ^ (8'h01 << i);
			@(posedge clk);
			gpio_in <= exp_lv;
			get_frame();
			check_event_frame(exp_lv);
		end
		@(posedge clk);
		gpio_in <= gpio_in ^ 8'h80;
		repeat (20) @(posedge clk);
		if (rx_q.size() != 0) begin
			$display("ERROR at %0t ns: change on a disabled pad sent %0d bytes",
				$time, rx_q.size());
			errors++;
			rx_q.delete();
		end
		end_test("gpio change events", err0);
	endtask

	// Random stalls on the host side during one query
	task automatic query_under_backpressure();
		int err0;
		ice_bus_pkg::char_t id;
		err0 = errors;
		id = 8'($urandom);
		bp_done = 1'b0;
		fork
			begin
				send_frame(CH_VERSION, id, 8'd0, 8'd0, 8'd0);
				get_frame();
				bp_done = 1'b1;
			end
			while (!bp_done) begin
				@(posedge clk);
				tx_char_ready <= bp_done ? 1'b1 : 1'($urandom_range(1, 0));
			end
		join
		@(posedge clk);
		tx_char_ready <= 1'b1;
		check_query_reply(id);
		end_test("query under back-pressure", err0);
	endtask

	// Both requests pend while the host stalls, then drain
	task automatic event_query_collision(logic event_first, ice_reg_pkg::gpio_vec_t mask);
		int err0;
		int n;
		logic seen_query;
		logic seen_event;
		ice_bus_pkg::char_t id;
		ice_reg_pkg::gpio_vec_t exp_lv;
		err0 = errors;
		id = 8'($urandom);
		exp_lv = gpio_in ^ mask;
		seen_query = 1'b0;
		seen_event = 1'b0;
		@(posedge clk);
		tx_char_ready <= 1'b0;
		if (event_first) begin
			@(posedge clk);
			gpio_in <= exp_lv;
			send_frame(CH_VERSION, id, 8'd0, 8'd0, 8'd0);
		end else begin
			send_frame(CH_VERSION, id, 8'd0, 8'd0, 8'd0);
			gpio_in <= exp_lv;
		end
		repeat (10) @(posedge clk);
		tx_char_ready <= 1'b1;
		for (n = 0; n < 2; n++) begin
			get_frame();
			if (f_addr == CH_VERSION) begin
				check_query_reply(id);
				seen_query = 1'b1;
			end else begin
				check_event_frame(exp_lv);
				seen_event = 1'b1;
			end
		end
		if (!seen_query || !seen_event) begin
			$display("ERROR at %0t ns: expected one query reply and one event frame",
				$time);
			errors++;
		end
		end_test(event_first ? "event then query" : "query then event", err0);
	endtask

	// Hard stop if a test hangs
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'hd9ec1276));
		reset = 1'b1;
		rx_char = '0;
		rx_char_valid = 1'b0;
		tx_char_ready = 1'b1;
		gpio_in = '0;
		tag_known = 1'b0;
		next_tag = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		query_version();
		write_direction_level();
		write_bad_select();
		gpio_change_events();
		query_under_backpressure();
		event_query_collision(1'b0, 8'h02);
		event_query_collision(1'b1, 8'h04);
		$display("Tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
